// File: logic/led_driver_pkg.sv
`default_nettype none

package led_driver_pkg;

    ////////////////////////////////////////////////////////////
    // Chain geometry
    ////////////////////////////////////////////////////////////

    // Parallel sin lines, all sharing sclk, lat and gclk
    localparam int unsigned N_CHAINS         = 4;
    localparam int unsigned PIXELS_PER_CHAIN = 3;
    localparam int unsigned WORD_BITS        = 48;

    localparam int unsigned PIX_IDX_W =
        (PIXELS_PER_CHAIN > 1) ? $clog2(PIXELS_PER_CHAIN) : 1;
    localparam int unsigned BIT_CNT_W = $clog2(WORD_BITS + 1);

    ////////////////////////////////////////////////////////////
    // Latch command lengths, in sclk rising edges
    ////////////////////////////////////////////////////////////

    localparam int unsigned LAT_LEN_W = 3;

    localparam logic [LAT_LEN_W-1:0] LAT_WRTGS = 3'd1;
    localparam logic [LAT_LEN_W-1:0] LAT_LATGS = 3'd3;
    localparam logic [LAT_LEN_W-1:0] LAT_WRTFC = 3'd5;

    // Grayscale clock
    localparam int unsigned BLANK_CYCLES = 72;
    localparam int unsigned GCLK_DIV     = 2;
    localparam int unsigned BLANK_CNT_W  = $clog2(BLANK_CYCLES + 1);
    localparam int unsigned GCLK_CNT_W   = $clog2(GCLK_DIV + 1);

    ////////////////////////////////////////////////////////////
    // Driver word layouts
    ////////////////////////////////////////////////////////////

    // Function configuration, MSB first on the wire
    typedef struct packed {
        logic [2:0] bc_red;
        logic [2:0] bc_green;
        logic [2:0] bc_blue;
        logic [8:0] cc_red;
        logic [8:0] cc_green;
        logic [8:0] cc_blue;
        logic [1:0] lodvth;
        logic       espwm;
        logic [8:0] reserved;
    } conf_fields_t;

    typedef struct packed {
        logic [15:0] red;
        logic [15:0] green;
        logic [15:0] blue;
    } gs_pixel_t;

    // Same 48 bits, meaning set by the latch length
    typedef union packed {
        conf_fields_t conf;
        gs_pixel_t    gs;
    } driver_word_u;

    // Sequencer to shifter
    typedef struct packed {
        logic                 start;
        logic [LAT_LEN_W-1:0] lat_len;
    } shift_cmd_t;

    // Board pins
    typedef struct packed {
        logic                sclk;
        logic                lat;
        logic                gclk;
        logic [N_CHAINS-1:0] sin;
    } driver_pins_t;

endpackage

`default_nettype wire

// File: logic/driver_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module driver_sequencer
    import led_driver_pkg::*;
(
    input  logic                 clock_33,
    input  logic                 nrst,
    input  logic                 conf_load,
    input  logic                 frame_start,
    input  logic                 word_done,
    output logic                 load_conf,
    output logic                 fetch,
    output logic [PIX_IDX_W-1:0] pixel_index,
    output logic                 use_conf,
    output shift_cmd_t           cmd,
    output logic                 blank_start,
    output logic                 busy,
    output logic                 frame_done
);

    typedef enum logic [2:0] {
        s_idle,
        s_conf_shift,
        s_fetch,
        s_fetch_wait,
        s_pix_shift,
        s_finish
    } seq_state_t;

    seq_state_t           state;
    logic [PIX_IDX_W-1:0] pix_idx;
    logic                 accept;
    logic                 last_pix;

    // Finish is the frame_done cycle and already takes strobes
    assign accept   = (state == s_idle) || (state == s_finish);
    assign last_pix = (pix_idx == PIX_IDX_W'(PIXELS_PER_CHAIN - 1));

    ////////////////////////////////////////////////////////////
    // State register and shift commands
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state   <= s_idle;
            pix_idx <= '0;
            cmd     <= '0;
        end else begin
            // Start is a single-cycle pulse
            cmd.start <= 1'b0;

            case (state)
                s_idle, s_finish: begin
                    if (conf_load) begin
                        state       <= s_conf_shift;
                        cmd.start   <= 1'b1;
                        cmd.lat_len <= LAT_WRTFC;
                    end else if (frame_start) begin
                        state   <= s_fetch;
                        pix_idx <= '0;
                    end else begin
                        state <= s_idle;
                    end
                end

                s_conf_shift: begin
                    if (word_done)
                        state <= s_idle;
                end

                // One cycle of fetch, pixel arrives on the next one
                s_fetch: begin
                    state <= s_fetch_wait;
                end

                s_fetch_wait: begin
                    state       <= s_pix_shift;
                    cmd.start   <= 1'b1;
                    cmd.lat_len <= last_pix ? LAT_LATGS : LAT_WRTGS;
                end

                s_pix_shift: begin
                    if (word_done) begin
                        if (last_pix) begin
                            state <= s_finish;
                        end else begin
                            pix_idx <= pix_idx + PIX_IDX_W'(1);
                            state   <= s_fetch;
                        end
                    end
                end

                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Decoded outputs
    ////////////////////////////////////////////////////////////

    // Capture conf_word in the strobe cycle itself
    assign load_conf   = accept && conf_load;
    assign fetch       = (state == s_fetch);
    assign pixel_index = pix_idx;
    assign use_conf    = (state == s_conf_shift);

    // Frame latch done, blank the grayscale clock
    assign frame_done  = (state == s_finish);
    assign blank_start = frame_done;
    assign busy        = !accept;

endmodule

`default_nettype wire

// File: logic/word_loader.sv
`default_nettype none
`timescale 1ns/10ps

module word_loader
    import led_driver_pkg::*;
(
    input  logic                        clock_33,
    input  logic                        nrst,
    input  logic                        load_conf,
    input  conf_fields_t                conf_word,
    input  logic                        fetch,
    input  logic                        use_conf,
    input  gs_pixel_t    [N_CHAINS-1:0] pixel_data,
    output driver_word_u [N_CHAINS-1:0] words
);

    conf_fields_t              conf_q;
    gs_pixel_t    [N_CHAINS-1:0] pix_q;
    logic                      fetch_q;

    ////////////////////////////////////////////////////////////
    // Configuration register and fetch delay
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            conf_q  <= '0;
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= fetch;
            if (load_conf)
                conf_q <= conf_word;
        end
    end

    // Source answers one cycle after the fetch strobe
    always_ff @(posedge clock_33) begin
        if (fetch_q)
            pix_q <= pixel_data;
    end

    ////////////////////////////////////////////////////////////
    // Word select per chain
    ////////////////////////////////////////////////////////////

    // Same config goes to every driver in the chain set
    always_comb begin
        for (int c = 0; c < N_CHAINS; c++) begin
            if (use_conf)
                words[c].conf = conf_q;
            else
                words[c].gs = pix_q[c];
        end
    end

endmodule

`default_nettype wire

// File: logic/word_shifter.sv
`default_nettype none
`timescale 1ns/10ps

module word_shifter
    import led_driver_pkg::*;
(
    input  logic                        clock_33,
    input  logic                        nrst,
    input  shift_cmd_t                  cmd,
    input  driver_word_u [N_CHAINS-1:0] words,
    output logic                        sclk,
    output logic                        lat,
    output logic         [N_CHAINS-1:0] sin,
    output logic                        word_done
);

    logic [N_CHAINS-1:0][WORD_BITS-1:0] sreg;
    logic [BIT_CNT_W-1:0]               bits_left;
    logic [BIT_CNT_W-1:0]               bits_next;
    logic [LAT_LEN_W-1:0]               lat_len_q;
    logic                               active;

    assign bits_next = bits_left - BIT_CNT_W'(1);

    ////////////////////////////////////////////////////////////
    // Shift engine, one bit per two clock_33 cycles
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            active    <= 1'b0;
            sclk      <= 1'b0;
            lat       <= 1'b0;
            word_done <= 1'b0;
            bits_left <= '0;
            lat_len_q <= '0;
            sreg      <= '0;
        end else begin
            word_done <= 1'b0;

            if (!active) begin
                if (cmd.start) begin
                    active    <= 1'b1;
                    bits_left <= BIT_CNT_W'(WORD_BITS);
                    lat_len_q <= cmd.lat_len;
                    for (int c = 0; c < N_CHAINS; c++)
                        sreg[c] <= words[c];
                end
            end else if (!sclk) begin
                // sin has been stable for a full low phase
                sclk <= 1'b1;
            end else begin
                sclk      <= 1'b0;
                bits_left <= bits_next;
                for (int c = 0; c < N_CHAINS; c++)
                    sreg[c] <= {sreg[c][WORD_BITS-2:0], 1'b0};

                if (bits_left == BIT_CNT_W'(1)) begin
                    active    <= 1'b0;
                    lat       <= 1'b0;
                    word_done <= 1'b1;
                end else if (bits_next <= BIT_CNT_W'(lat_len_q)) begin
                    // Raise lat in the low phase ahead of its first edge
                    lat <= 1'b1;
                end
            end
        end
    end

    // MSB of each register drives its line
    always_comb begin
        for (int c = 0; c < N_CHAINS; c++)
            sin[c] = sreg[c][WORD_BITS-1];
    end

endmodule

`default_nettype wire

// File: logic/gclk_generator.sv
`default_nettype none
`timescale 1ns/10ps

module gclk_generator
    import led_driver_pkg::*;
(
    input  logic clock_33,
    input  logic nrst,
    input  logic blank_start,
    output logic gclk
);

    logic [BLANK_CNT_W-1:0] blank_cnt;
    logic [GCLK_CNT_W-1:0]  div_cnt;

    ////////////////////////////////////////////////////////////
    // Divider with blanking hold
    ////////////////////////////////////////////////////////////

    // Blank count leaves room for the divider low phase,
    // so gclk stays low BLANK_CYCLES cycles in total
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            gclk      <= 1'b0;
            blank_cnt <= '0;
            div_cnt   <= '0;
        end else if (blank_start) begin
            gclk      <= 1'b0;
            div_cnt   <= '0;
            blank_cnt <= BLANK_CNT_W'(BLANK_CYCLES - GCLK_DIV);
        end else if (blank_cnt != '0) begin
            blank_cnt <= blank_cnt - BLANK_CNT_W'(1);
        end else if (div_cnt == GCLK_CNT_W'(GCLK_DIV - 1)) begin
            div_cnt <= '0;
            gclk    <= ~gclk;
        end else begin
            div_cnt <= div_cnt + GCLK_CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: logic/led_driver_top.sv
`default_nettype none
`timescale 1ns/10ps

module led_driver_top
    import led_driver_pkg::*;
(
    input  logic                        clock_33,
    input  logic                        nrst,
    input  logic                        conf_load,
    input  conf_fields_t                conf_word,
    input  logic                        frame_start,
    input  gs_pixel_t    [N_CHAINS-1:0] pixel_data,
    output logic                        pixel_fetch,
    output logic         [PIX_IDX_W-1:0] pixel_index,
    output logic                        busy,
    output logic                        frame_done,
    output driver_pins_t                pins
);

    logic                        load_conf;
    logic                        use_conf;
    logic                        word_done;
    logic                        blank_start;
    shift_cmd_t                  cmd;
    driver_word_u [N_CHAINS-1:0] words;
    logic                        sclk;
    logic                        lat;
    logic                        gclk;
    logic         [N_CHAINS-1:0] sin;

    ////////////////////////////////////////////////////////////
    // Control and datapath
    ////////////////////////////////////////////////////////////

    driver_sequencer i_driver_sequencer (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .conf_load   (conf_load),
        .frame_start (frame_start),
        .word_done   (word_done),
        .load_conf   (load_conf),
        .fetch       (pixel_fetch),
        .pixel_index (pixel_index),
        .use_conf    (use_conf),
        .cmd         (cmd),
        .blank_start (blank_start),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    word_loader i_word_loader (
        .clock_33   (clock_33),
        .nrst       (nrst),
        .load_conf  (load_conf),
        .conf_word  (conf_word),
        .fetch      (pixel_fetch),
        .use_conf   (use_conf),
        .pixel_data (pixel_data),
        .words      (words)
    );

    word_shifter i_word_shifter (
        .clock_33  (clock_33),
        .nrst      (nrst),
        .cmd       (cmd),
        .words     (words),
        .sclk      (sclk),
        .lat       (lat),
        .sin       (sin),
        .word_done (word_done)
    );

    gclk_generator i_gclk_generator (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .blank_start (blank_start),
        .gclk        (gclk)
    );

    // Pin bundle
    assign pins.sclk = sclk;
    assign pins.lat  = lat;
    assign pins.gclk = gclk;
    assign pins.sin  = sin;

endmodule

`default_nettype wire

// File: tb/led_driver_tb.sv
`default_nettype none
`timescale 1ns/10ps

module led_driver_tb
    import led_driver_pkg::*;
();

    typedef enum {op_conf, op_frame, op_both} op_t;

    typedef struct {
        op_t          op;
        conf_fields_t conf;
        bit           inject;
    } row_t;

    logic                        clock_33 = 1'b0;
    logic                        nrst;
    logic                        conf_load;
    conf_fields_t                conf_word;
    logic                        frame_start;
    gs_pixel_t    [N_CHAINS-1:0] pixel_data = '0;
    logic                        pixel_fetch;
    logic         [PIX_IDX_W-1:0] pixel_index;
    logic                        busy;
    logic                        frame_done;
    driver_pins_t                pins;

    // Pixel source, one entry per index and chain
    gs_pixel_t    [N_CHAINS-1:0] pix_mem [PIXELS_PER_CHAIN];
    row_t                        rows [5];

    // Monitor state
    logic [N_CHAINS-1:0][WORD_BITS-1:0] acc = '0;
    driver_word_u [N_CHAINS-1:0] word_log [$];
    int                          lat_log [$];
    int                          rise_q [$];
    int                          lat_edges = 0;
    int                          cycle = 0;
    int                          fd_cycle = 0;
    int                          fd_count = 0;
    int                          fetch_count = 0;
    logic                        sclk_prev = 1'b0;
    logic                        lat_prev = 1'b0;
    logic                        gclk_prev = 1'b0;

    int errors = 0;
    int timeouts = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #4 clock_33 = ~clock_33;

    led_driver_top i_led_driver_top (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .conf_load   (conf_load),
        .conf_word   (conf_word),
        .frame_start (frame_start),
        .pixel_data  (pixel_data),
        .pixel_fetch (pixel_fetch),
        .pixel_index (pixel_index),
        .busy        (busy),
        .frame_done  (frame_done),
        .pins        (pins)
    );

    // Source answers a fetch on the following cycle
    always @(posedge clock_33) begin
        if (pixel_fetch)
            pixel_data <= pix_mem[pixel_index];
    end

    ////////////////////////////////////////////////////////////
    // Serial capture monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clock_33) begin
        driver_word_u [N_CHAINS-1:0] entry;
        if (nrst) begin
            cycle = cycle + 1;
            if (pixel_fetch)
                fetch_count++;
            if (pins.sclk && !sclk_prev) begin
                for (int c = 0; c < N_CHAINS; c++)
                    acc[c] = {acc[c][WORD_BITS-2:0], pins.sin[c]};
                if (pins.lat)
                    lat_edges++;
            end
            // End of word
            if (!pins.lat && lat_prev) begin
                entry = acc;
                word_log.push_back(entry);
                lat_log.push_back(lat_edges);
                lat_edges = 0;
            end
            if (pins.gclk && !gclk_prev)
                rise_q.push_back(cycle);
            if (frame_done) begin
                fd_count++;
                fd_cycle = cycle;
                rise_q.delete();
            end
        end
        sclk_prev = pins.sclk;
        lat_prev  = pins.lat;
        gclk_prev = pins.gclk;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input driver_word_u got, input driver_word_u exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_lat(input int got,
                             input logic [LAT_LEN_W-1:0] exp, input string what);
        if (got != int'(exp)) begin
            $display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic wait_busy(input logic level, input int limit);
        bit ok;
        ok = 1'b0;
        for (int n = 0; n < limit; n++) begin
            @(posedge clock_33);
            if (busy == level) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timed out after %0d cycles waiting for busy to become %0d",
                     limit, level);
            timeouts++;
        end
    endtask

    task automatic wait_gclk_rises(input int count, input int limit);
        bit ok;
        ok = 1'b0;
        for (int n = 0; n < limit; n++) begin
            @(posedge clock_33);
            if (rise_q.size() >= count) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timed out waiting for the grayscale clock to restart");
            timeouts++;
        end
    endtask

    task automatic fill_pixels();
        for (int i = 0; i < PIXELS_PER_CHAIN; i++) begin
            for (int c = 0; c < N_CHAINS; c++) begin
                pix_mem[i][c].red   = 16'($urandom());
                pix_mem[i][c].green = 16'($urandom());
                pix_mem[i][c].blue  = 16'($urandom());
            end
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        tests_run++;
        if (errors + timeouts != fails_before) begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
    endtask

    task automatic check_reset_idle();
        int idle;
        int fails0;
        idle   = 0;
        fails0 = errors + timeouts;
        // gclk runs freely from reset, so only the shift pins count
        for (int n = 0; n < 20; n++) begin
            @(posedge clock_33);
            if (!pins.sclk && !pins.lat && pins.sin == '0 && !busy && !pixel_fetch &&
                !frame_done)
                idle++;
        end
        check_count(idle, 20, "quiet cycles after reset");
        report_test("reset idle", fails0);
    endtask

    ////////////////////////////////////////////////////////////
    // One table row
    ////////////////////////////////////////////////////////////

    task automatic run_row(input int r);
        driver_word_u [N_CHAINS-1:0] w;
        driver_word_u [N_CHAINS-1:0] exp_words [$];
        logic [LAT_LEN_W-1:0]        exp_lat [$];
        int                          fails0;
        int                          fd0;
        int                          fetch0;
        int                          idle;
        bit                          is_frame;

        fails0   = errors + timeouts;
        is_frame = (rows[r].op == op_frame);
        word_log.delete();
        lat_log.delete();

        // Expected words from the serial format rules
        if (is_frame) begin
            fill_pixels();
            for (int i = 0; i < PIXELS_PER_CHAIN; i++) begin
                for (int c = 0; c < N_CHAINS; c++)
                    w[c].gs = pix_mem[i][c];
                exp_words.push_back(w);
                exp_lat.push_back((i == PIXELS_PER_CHAIN - 1) ? LAT_LATGS : LAT_WRTGS);
            end
        end else begin
            for (int c = 0; c < N_CHAINS; c++)
                w[c].conf = rows[r].conf;
            exp_words.push_back(w);
            exp_lat.push_back(LAT_WRTFC);
        end

        @(posedge clock_33);
        fd0    = fd_count;
        fetch0 = fetch_count;
        conf_word <= rows[r].conf;
        if (rows[r].op != op_frame)
            conf_load <= 1'b1;
        if (rows[r].op != op_conf)
            frame_start <= 1'b1;
        @(posedge clock_33);
        conf_load   <= 1'b0;
        frame_start <= 1'b0;

        wait_busy(1'b1, 10);
        if (rows[r].inject) begin
            // Strobes in the middle of a busy word
            repeat (10) @(posedge clock_33);
            conf_load   <= 1'b1;
            frame_start <= 1'b1;
            conf_word   <= conf_fields_t'(48'hdead_beef_0bad);
            @(posedge clock_33);
            conf_load   <= 1'b0;
            frame_start <= 1'b0;
        end
        wait_busy(1'b0, 2000);

        idle = 0;
        for (int n = 0; n < 8; n++) begin
            @(posedge clock_33);
            if (!busy)
                idle++;
        end
        check_count(idle, 8, "idle cycles after operation");

        check_count(word_log.size(), exp_words.size(), "word count");
        for (int i = 0; i < exp_words.size() && i < word_log.size(); i++) begin
            for (int c = 0; c < N_CHAINS; c++)
                check_word(word_log[i][c], exp_words[i][c],
                           $sformatf("word %0d chain %0d", i, c));
            check_lat(lat_log[i], exp_lat[i], $sformatf("lat of word %0d", i));
        end
        check_count(fd_count - fd0, is_frame ? 1 : 0, "frame_done pulses");
        check_count(fetch_count - fetch0, is_frame ? PIXELS_PER_CHAIN : 0, "pixel fetches");

        if (is_frame) begin
            wait_gclk_rises(3, 200);
            if (rise_q.size() >= 3) begin
                check_count(rise_q[0] - fd_cycle - 1, BLANK_CYCLES, "gclk blank cycles");
                check_count(rise_q[1] - rise_q[0], 2 * GCLK_DIV, "gclk period");
                check_count(rise_q[2] - rise_q[1], 2 * GCLK_DIV, "gclk period");
            end
        end

        case (rows[r].op)
            op_conf:  report_test(rows[r].inject ? "conf with strobes" : "conf", fails0);
            op_frame: report_test(rows[r].inject ? "frame with strobes" : "frame", fails0);
            default:  report_test("conf and frame together", fails0);
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        nrst        = 1'b0;
        conf_load   = 1'b0;
        frame_start = 1'b0;
        conf_word   = '0;
        void'($urandom(78));

        rows[0] = '{op_conf,  conf_fields_t'(48'ha5f0_3c96_7e21), 1'b0};
        rows[1] = '{op_frame, conf_fields_t'(48'h0),              1'b1};
        rows[2] = '{op_conf,  conf_fields_t'(48'h1234_5678_9abc), 1'b1};
        rows[3] = '{op_both,  conf_fields_t'(48'h0f0f_f0f0_c3c3), 1'b0};
        rows[4] = '{op_frame, conf_fields_t'(48'h0),              1'b0};

        repeat (16) @(posedge clock_33);
        nrst <= 1'b1;

        check_reset_idle();
        for (int r = 0; r < 5; r++)
            run_row(r);

        $display("tests %0d, failed %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, errors, timeouts);
        if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: led_driver_top.f
logic/led_driver_pkg.sv
logic/driver_sequencer.sv
logic/word_loader.sv
logic/word_shifter.sv
logic/gclk_generator.sv
logic/led_driver_top.sv
tb/led_driver_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LED driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module led_driver_tb \
    -f led_driver_top.f \
    -o led_driver_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/led_driver_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0
